//--- filelist.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_way.sv
verilog/dcache_controller.sv
verilog/dcache_hit_merge.sv
verilog/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

//--- Makefile
# Verilator build and run of the data cache testbench

TOP := dcache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- verification/dcache_tb.sv
// Testbench for the 2-way data cache.
// Applies a table of CPU reads and writes to dcache_top with a behavioral
// memory behind it, and checks read data, latency and memory traffic.

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;

    localparam int NUM_STEPS      = 13;
    localparam int TIMEOUT_CYCLES = 2000;

    // One table row with request, expected word, hit flag and write-back beats
    typedef struct packed {
        logic                      we;
        logic [`DCACHE_ADDR_W-1:0] addr;
        logic [`DCACHE_DATA_W-1:0] data;
        logic [1:0]                bytesel;
        logic [`DCACHE_DATA_W-1:0] exp_rdata;
        logic                      exp_hit;
        logic [3:0]                exp_wr;
        logic [`DCACHE_ADDR_W-1:0] wb_line;
    } step_t;

    logic                      clk;
    logic                      reset;
    dcache_pkg::cpu_req_t      c_req;
    logic                      c_access;
    logic                      c_ack;
    logic [`DCACHE_DATA_W-1:0] c_rdata;
    dcache_pkg::mem_req_t      m_req;
    logic                      m_access;
    logic                      m_ack;
    logic [`DCACHE_DATA_W-1:0] m_rdata;

    step_t                     steps [NUM_STEPS];
    logic [`DCACHE_DATA_W-1:0] ref_mem [logic [`DCACHE_ADDR_W-1:0]];
    int                        rd_beats;
    int                        wr_beats;
    int                        step_errors;
    int                        passed;
    int                        failed;
    logic                      timed_out;

    dcache_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .c_req    (c_req),
        .c_access (c_access),
        .c_ack    (c_ack),
        .c_rdata  (c_rdata),
        .m_req    (m_req),
        .m_access (m_access),
        .m_ack    (m_ack),
        .m_rdata  (m_rdata)
    );

    dcache_mem_model u_mem (
        .clk      (clk),
        .reset    (reset),
        .m_req    (m_req),
        .m_access (m_access),
        .m_ack    (m_ack),
        .m_rdata  (m_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Completed memory beats by direction
    always @(posedge clk) begin
        if (!reset && m_access && m_ack) begin
            if (m_req.we)
                wr_beats <= wr_beats + 1;
            else
                rd_beats <= rd_beats + 1;
        end
    end

    // --------------------------------------------------
    // Reference memory
    // --------------------------------------------------
    function automatic logic [`DCACHE_DATA_W-1:0] ref_word(input logic [`DCACHE_ADDR_W-1:0] a);
        if (ref_mem.exists(a))
            return ref_mem[a];
        return 16'(32'(a) * 32'd5 + 32'd3);
    endfunction

    function automatic logic [`DCACHE_DATA_W-1:0] merge_bytes(
        input logic [`DCACHE_DATA_W-1:0] old_word,
        input logic [`DCACHE_DATA_W-1:0] new_word,
        input logic [1:0]                bytesel
    );
        return {bytesel[1] ? new_word[15:8] : old_word[15:8],
                bytesel[0] ? new_word[7:0] : old_word[7:0]};
    endfunction

    task automatic fail_check(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        step_errors++;
    endtask

    // Set 2 throughout with tags 1 to 4 at lines 0x090, 0x110, 0x190 and 0x210
    task automatic load_table();
        steps[0]  = '{1'b0, 19'h00093, 16'h0000, 2'b00, 16'h02E2, 1'b0, 4'd0, 19'h0};
        steps[1]  = '{1'b0, 19'h00095, 16'h0000, 2'b00, 16'h02EC, 1'b1, 4'd0, 19'h0};
        steps[2]  = '{1'b1, 19'h00095, 16'hAB00, 2'b10, 16'h0000, 1'b1, 4'd0, 19'h0};
        steps[3]  = '{1'b0, 19'h00095, 16'h0000, 2'b00, 16'hABEC, 1'b1, 4'd0, 19'h0};
        steps[4]  = '{1'b0, 19'h00111, 16'h0000, 2'b00, 16'h0558, 1'b0, 4'd0, 19'h0};
        steps[5]  = '{1'b0, 19'h00190, 16'h0000, 2'b00, 16'h07D3, 1'b0, 4'd8, 19'h00090};
        steps[6]  = '{1'b0, 19'h00111, 16'h0000, 2'b00, 16'h0558, 1'b1, 4'd0, 19'h0};
        steps[7]  = '{1'b0, 19'h00095, 16'h0000, 2'b00, 16'hABEC, 1'b0, 4'd0, 19'h0};
        steps[8]  = '{1'b0, 19'h00111, 16'h0000, 2'b00, 16'h0558, 1'b1, 4'd0, 19'h0};
        steps[9]  = '{1'b1, 19'h00212, 16'h0034, 2'b01, 16'h0000, 1'b0, 4'd0, 19'h0};
        steps[10] = '{1'b0, 19'h00212, 16'h0000, 2'b00, 16'h0A34, 1'b1, 4'd0, 19'h0};
        steps[11] = '{1'b0, 19'h00197, 16'h0000, 2'b00, 16'h07F6, 1'b0, 4'd0, 19'h0};
        steps[12] = '{1'b0, 19'h00090, 16'h0000, 2'b00, 16'h02D3, 1'b0, 4'd8, 19'h00210};
    endtask

    task automatic count_result(input string name);
        $display("%s: %s", name, (step_errors == 0) ? "ok" : "failed");
        if (step_errors == 0)
            passed++;
        else
            failed++;
    endtask

    // --------------------------------------------------
    // One table row
    // --------------------------------------------------
    task automatic run_step(input int idx);
        step_t                     s;
        dcache_pkg::cpu_req_t      req;
        int                        cycles;
        int                        rd_start;
        int                        wr_start;
        logic                      acked;
        logic [`DCACHE_DATA_W-1:0] rdata;
        logic [`DCACHE_ADDR_W-1:0] a;
        s           = steps[idx];
        req.addr    = s.addr;
        req.wdata   = s.data;
        req.bytesel = s.bytesel;
        req.we      = s.we;
        step_errors = 0;
        cycles      = 0;
        acked       = 1'b0;
        rdata       = '0;
        @(posedge clk);
        rd_start = rd_beats;
        wr_start = wr_beats;
        c_req    <= req;
        c_access <= 1'b1;
        while (!acked && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (c_ack) begin
                acked = 1'b1;
                rdata = c_rdata;
            end
        end
        if (!acked) begin
            $display("step %0d timed out: no c_ack within %0d cycles", idx, TIMEOUT_CYCLES);
            timed_out = 1'b1;
            failed++;
            return;
        end
        @(posedge clk);
        c_access <= 1'b0;
        if (s.we)
            ref_mem[s.addr] = merge_bytes(ref_word(s.addr), s.data, s.bytesel);
        else
            assert (rdata == s.exp_rdata)
            else fail_check($sformatf("step %0d read %h, expected %h", idx, rdata, s.exp_rdata));
        if (s.exp_hit) begin
            assert (cycles == 2)
            else fail_check($sformatf("step %0d hit took %0d cycles, expected 2", idx, cycles));
            assert (rd_beats == rd_start && wr_beats == wr_start)
            else fail_check($sformatf("step %0d hit accessed memory", idx));
        end else begin
            assert (rd_beats - rd_start == 8)
            else fail_check($sformatf("step %0d read %0d fill beats, expected 8",
                                      idx, rd_beats - rd_start));
            assert (wr_beats - wr_start == int'(s.exp_wr))
            else fail_check($sformatf("step %0d wrote %0d beats, expected %0d",
                                      idx, wr_beats - wr_start, s.exp_wr));
        end
        // The written-back line must now sit in memory
        if (s.exp_wr != 0) begin
            for (int o = 0; o < `DCACHE_LINE_WORDS; o++) begin
                a = s.wb_line + 19'(o);
                assert (u_mem.read_word(a) == ref_word(a))
                else fail_check($sformatf("memory at %h holds %h, expected %h",
                                          a, u_mem.read_word(a), ref_word(a)));
            end
        end
        count_result($sformatf("step %0d %s %h", idx, s.we ? "write" : "read", s.addr));
    endtask

    initial begin
        reset     = 1'b1;
        c_access  = 1'b0;
        c_req     = '0;
        rd_beats  = 0;
        wr_beats  = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        load_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        step_errors = 0;
        assert (!c_ack && !m_access)
        else fail_check("c_ack or m_access high after reset");
        count_result("reset state");

        for (int i = 0; i < NUM_STEPS && !timed_out; i++)
            run_step(i);

        $display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0 && !timed_out)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- verification/dcache_assert.sv
// Protocol assertions for the data cache that bind into dcache_top.
// Covers the memory handshake, the CPU ack and the state after reset.

`timescale 1ns/1ps

module dcache_assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 c_access,
    input logic                 c_ack,
    input dcache_pkg::mem_req_t m_req,
    input logic                 m_access,
    input logic                 m_ack
);

    // Memory request held until the memory acknowledges it
    m_req_held: assert property (
        @(posedge clk) disable iff (reset)
        (m_access && !m_ack) |=> (m_access && $stable(m_req))
    ) else $error("m_req or m_access changed before m_ack");

    c_ack_with_access: assert property (
        @(posedge clk) disable iff (reset)
        c_ack |-> c_access
    ) else $error("c_ack without c_access");

    // No memory traffic in the first cycle out of reset
    idle_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !m_access
    ) else $error("m_access high right after reset");

endmodule

bind dcache_top dcache_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .c_access (c_access),
    .c_ack    (c_ack),
    .m_req    (m_req),
    .m_access (m_access),
    .m_ack    (m_ack)
);

//--- verification/dcache_mem_model.sv
// Behavioral word memory behind the data cache in the testbench.
// Acknowledges each access after 1 to 3 cycles and keeps written words.
// Words never written read as a pattern of their address.

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_mem_model (
    input  logic                      clk,
    input  logic                      reset,
    input  dcache_pkg::mem_req_t      m_req,
    input  logic                      m_access,
    output logic                      m_ack,
    output logic [`DCACHE_DATA_W-1:0] m_rdata
);

    logic [`DCACHE_DATA_W-1:0] words [logic [`DCACHE_ADDR_W-1:0]];
    logic [31:0]               lcg_state;
    logic [1:0]                wait_cnt;
    logic                      busy;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Stored word, or address times 5 plus 3 if never written
    function automatic logic [`DCACHE_DATA_W-1:0] read_word(
        input logic [`DCACHE_ADDR_W-1:0] a
    );
        if (words.exists(a))
            return words[a];
        return 16'(32'(a) * 32'd5 + 32'd3);
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_ack     <= 1'b0;
            m_rdata   <= '0;
            busy      <= 1'b0;
            wait_cnt  <= '0;
            lcg_state <= 32'd41576;
        end else begin
            m_ack <= 1'b0;
            if (busy) begin
                if (wait_cnt == 2'd1) begin
                    busy    <= 1'b0;
                    m_ack   <= 1'b1;
                    m_rdata <= read_word(m_req.addr);
                    if (m_req.we)
                        words[m_req.addr] = m_req.wdata;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (m_access && !m_ack) begin
                // Draw the delay of a new beat
                busy      <= 1'b1;
                wait_cnt  <= 2'd1 + 2'(lcg_state[23:16] % 8'd3);
                lcg_state <= lcg_next(lcg_state);
            end
        end
    end

endmodule

//--- verilog/dcache_top.sv
// Top level of the 2-way write-back data cache.
// CPU side and memory side both use an access/ack handshake.

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                       clk,
    input  logic                       reset,
    input  dcache_pkg::cpu_req_t       c_req,
    input  logic                       c_access,
    output logic                       c_ack,
    output logic [`DCACHE_DATA_W-1:0]  c_rdata,
    output dcache_pkg::mem_req_t       m_req,
    output logic                       m_access,
    input  logic                       m_ack,
    input  logic [`DCACHE_DATA_W-1:0]  m_rdata
);

    dcache_pkg::way_cmd_t      way_cmd;
    dcache_pkg::way_result_t   results [`DCACHE_WAYS];
    logic                      hit;
    logic                      hit_way;
    logic                      lookup;
    logic                      victim_valid;
    logic                      victim_dirty;
    logic [`DCACHE_TAG_W-1:0]  victim_tag;
    logic [`DCACHE_DATA_W-1:0] victim_word;

    dcache_controller u_controller (
        .clk          (clk),
        .reset        (reset),
        .c_req        (c_req),
        .c_access     (c_access),
        .m_ack        (m_ack),
        .m_rdata      (m_rdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_word  (victim_word),
        .way_cmd      (way_cmd),
        .m_req        (m_req),
        .m_access     (m_access),
        .lookup       (lookup)
    );

    // One storage block per way
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_way #(
            .WAY_ID (w)
        ) u_way (
            .clk     (clk),
            .reset   (reset),
            .way_cmd (way_cmd),
            .result  (results[w])
        );
    end

    dcache_hit_merge u_hit_merge (
        .results      (results),
        .lookup       (lookup),
        .victim_way   (way_cmd.way_sel),
        .hit          (hit),
        .hit_way      (hit_way),
        .c_ack        (c_ack),
        .c_rdata      (c_rdata),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_word  (victim_word)
    );

endmodule

//--- verilog/dcache_hit_merge.sv
// Merges the per-way results into one hit, the CPU read data and ack,
// and the fields of the victim way that the controller asks for.

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_hit_merge (
    input  dcache_pkg::way_result_t    results [`DCACHE_WAYS],
    input  logic                       lookup,
    input  logic                       victim_way,
    output logic                       hit,
    output logic                       hit_way,
    output logic                       c_ack,
    output logic [`DCACHE_DATA_W-1:0]  c_rdata,
    output logic                       victim_valid,
    output logic                       victim_dirty,
    output logic [`DCACHE_TAG_W-1:0]   victim_tag,
    output logic [`DCACHE_DATA_W-1:0]  victim_word
);

    // --------------------------------------------------
    // Hit detection and read data
    // --------------------------------------------------
    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        c_rdata = '0;
        // At most one way hits, so AND-OR muxing is enough
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (results[w].hit) begin
                hit     = 1'b1;
                hit_way = 1'(w);
            end
            c_rdata = c_rdata | (results[w].rdata & {`DCACHE_DATA_W{results[w].hit}});
        end
    end

    // Ack only in the lookup cycle
    assign c_ack = lookup && hit;

    // --------------------------------------------------
    // Victim fields
    // --------------------------------------------------
    always_comb begin
        victim_valid = results[victim_way].valid;
        victim_dirty = results[victim_way].dirty;
        victim_tag   = results[victim_way].tag;
        victim_word  = results[victim_way].wb_word;
    end

endmodule

//--- verilog/dcache_controller.sv
// Request latch, LRU bits and the miss state machine of the data cache.
// A miss writes back a dirty victim, fills the line from memory and then
// retries the lookup, which hits and acks the CPU.

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_controller (
    input  logic                       clk,
    input  logic                       reset,
    input  dcache_pkg::cpu_req_t       c_req,
    input  logic                       c_access,
    input  logic                       m_ack,
    input  logic [`DCACHE_DATA_W-1:0]  m_rdata,
    input  logic                       hit,
    input  logic                       hit_way,
    input  logic                       victim_valid,
    input  logic                       victim_dirty,
    input  logic [`DCACHE_TAG_W-1:0]   victim_tag,
    input  logic [`DCACHE_DATA_W-1:0]  victim_word,
    output dcache_pkg::way_cmd_t       way_cmd,
    output dcache_pkg::mem_req_t       m_req,
    output logic                       m_access,
    output logic                       lookup
);

    dcache_pkg::ctrl_state_t     state;
    dcache_pkg::cpu_req_t        req_q;
    logic [`DCACHE_SETS-1:0]     lru;
    logic                        victim_way;
    logic [`DCACHE_OFFSET_W-1:0] beat;

    logic [`DCACHE_TAG_W-1:0]    req_tag;
    logic [`DCACHE_INDEX_W-1:0]  req_index;
    logic                        last_beat;
    logic                        fill_beat;

    assign req_tag   = req_q.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign req_index = req_q.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign last_beat = &beat;

    assign lookup    = (state == dcache_pkg::ST_LOOKUP);
    assign fill_beat = (state == dcache_pkg::ST_FILL) && m_ack;

    // --------------------------------------------------
    // Way command
    // --------------------------------------------------
    always_comb begin
        way_cmd.addr        = req_q.addr;
        way_cmd.wdata       = req_q.wdata;
        way_cmd.bytesel     = req_q.bytesel;
        way_cmd.write_hit   = lookup && req_q.we;
        way_cmd.fill_en     = fill_beat;
        way_cmd.fill_word   = m_rdata;
        way_cmd.fill_offset = beat;
        // During lookup the LRU bit names the victim before it is latched
        way_cmd.way_sel     = lookup ? lru[req_index] : victim_way;
        way_cmd.line_done   = fill_beat && last_beat;
        way_cmd.wb_offset   = beat;
    end

    // --------------------------------------------------
    // Memory port
    // --------------------------------------------------
    assign m_access = (state == dcache_pkg::ST_WRITEBACK) || (state == dcache_pkg::ST_FILL);

    always_comb begin
        m_req.wdata = victim_word;
        m_req.we    = (state == dcache_pkg::ST_WRITEBACK);
        if (state == dcache_pkg::ST_WRITEBACK)
            m_req.addr = {victim_tag, req_index, beat};
        else
            m_req.addr = {req_tag, req_index, beat};
    end

    // Request latched only when idle
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::ST_IDLE && c_access)
            req_q <= c_req;
    end

    // --------------------------------------------------
    // State machine and LRU
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= dcache_pkg::ST_IDLE;
            lru        <= '0;
            victim_way <= 1'b0;
            beat       <= '0;
        end else begin
            case (state)
                dcache_pkg::ST_IDLE: begin
                    if (c_access)
                        state <= dcache_pkg::ST_LOOKUP;
                end

                dcache_pkg::ST_LOOKUP: begin
                    beat <= '0;
                    if (hit) begin
                        // Point at the way that was not just used
                        lru[req_index] <= ~hit_way;
                        state          <= dcache_pkg::ST_IDLE;
                    end else begin
                        victim_way <= lru[req_index];
                        if (victim_valid && victim_dirty)
                            state <= dcache_pkg::ST_WRITEBACK;
                        else
                            state <= dcache_pkg::ST_FILL;
                    end
                end

                dcache_pkg::ST_WRITEBACK: begin
                    if (m_ack) begin
                        beat <= beat + 1'b1;
                        if (last_beat)
                            state <= dcache_pkg::ST_FILL;
                    end
                end

                dcache_pkg::ST_FILL: begin
                    if (m_ack) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            lru[req_index] <= ~victim_way;
                            state          <= dcache_pkg::ST_RETRY;
                        end
                    end
                end

                // Line is in place so the request is looked up again
                dcache_pkg::ST_RETRY: begin
                    state <= dcache_pkg::ST_LOOKUP;
                end

                default: begin
                    state <= dcache_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/dcache_way.sv
// One way of the data cache with its tag, valid, dirty and data storage.
// All ways see the same command; WAY_ID picks which one takes fills.
// Reads are asynchronous, writes happen on the rising clock edge.

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_way #(
    parameter int unsigned WAY_ID = 0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  dcache_pkg::way_cmd_t     way_cmd,
    output dcache_pkg::way_result_t  result
);

    localparam int LINE_ADDR_W = `DCACHE_INDEX_W + `DCACHE_OFFSET_W;
    localparam int WORDS       = `DCACHE_SETS * `DCACHE_LINE_WORDS;

    logic [`DCACHE_TAG_W-1:0]  tag_mem [`DCACHE_SETS];
    logic [`DCACHE_DATA_W-1:0] data_mem [WORDS];
    logic [`DCACHE_SETS-1:0]   valid_bits;
    logic [`DCACHE_SETS-1:0]   dirty_bits;

    logic [`DCACHE_TAG_W-1:0]    lookup_tag;
    logic [`DCACHE_INDEX_W-1:0]  lookup_index;
    logic [`DCACHE_OFFSET_W-1:0] lookup_offset;
    logic                        selected;
    logic                        hit;
    logic                        do_write;
    logic [`DCACHE_DATA_W-1:0]   merged_word;

    // --------------------------------------------------
    // Address split and tag compare
    // --------------------------------------------------
    assign lookup_tag    = way_cmd.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign lookup_index  = way_cmd.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign lookup_offset = way_cmd.addr[`DCACHE_OFFSET_W-1:0];

    assign selected = (way_cmd.way_sel == 1'(WAY_ID));
    assign hit      = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign do_write = way_cmd.write_hit && hit;

    always_comb begin
        result.hit     = hit;
        result.valid   = valid_bits[lookup_index];
        result.dirty   = dirty_bits[lookup_index];
        result.tag     = tag_mem[lookup_index];
        result.rdata   = data_mem[LINE_ADDR_W'({lookup_index, lookup_offset})];
        result.wb_word = data_mem[LINE_ADDR_W'({lookup_index, way_cmd.wb_offset})];
    end

    // Byte merge of the CPU write into the stored word
    always_comb begin
        merged_word = result.rdata;
        if (way_cmd.bytesel[0])
            merged_word[7:0] = way_cmd.wdata[7:0];
        if (way_cmd.bytesel[1])
            merged_word[15:8] = way_cmd.wdata[15:8];
    end

    // --------------------------------------------------
    // Storage updates
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_write)
            data_mem[LINE_ADDR_W'({lookup_index, lookup_offset})] <= merged_word;
        else if (way_cmd.fill_en && selected)
            data_mem[LINE_ADDR_W'({lookup_index, way_cmd.fill_offset})] <= way_cmd.fill_word;

        // New tag goes in with the last fill word
        if (way_cmd.line_done && selected)
            tag_mem[lookup_index] <= lookup_tag;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (do_write)
                dirty_bits[lookup_index] <= 1'b1;
            if (way_cmd.line_done && selected) begin
                valid_bits[lookup_index] <= 1'b1;
                dirty_bits[lookup_index] <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/dcache_pkg.sv
// Shared types of the data cache.
// RTL files refer to these by scoped names, e.g. dcache_pkg::way_cmd_t.

`include "dcache_settings.svh"

package dcache_pkg;

    // CPU request held stable by the CPU until c_ack
    typedef struct packed {
        logic [`DCACHE_ADDR_W-1:0] addr;
        logic [`DCACHE_DATA_W-1:0] wdata;
        logic [1:0]                bytesel;
        logic                      we;
    } cpu_req_t;

    // Memory beat that always carries a full word
    typedef struct packed {
        logic [`DCACHE_ADDR_W-1:0] addr;
        logic [`DCACHE_DATA_W-1:0] wdata;
        logic                      we;
    } mem_req_t;

    // Controller to way command shared by all ways
    typedef struct packed {
        logic [`DCACHE_ADDR_W-1:0]   addr;
        logic [`DCACHE_DATA_W-1:0]   wdata;
        logic [1:0]                  bytesel;
        logic                        write_hit;
        logic                        fill_en;
        logic [`DCACHE_DATA_W-1:0]   fill_word;
        logic [`DCACHE_OFFSET_W-1:0] fill_offset;
        logic                        way_sel;
        logic                        line_done;
        logic [`DCACHE_OFFSET_W-1:0] wb_offset;
    } way_cmd_t;

    // Per way lookup result
    typedef struct packed {
        logic                      hit;
        logic                      valid;
        logic                      dirty;
        logic [`DCACHE_TAG_W-1:0]  tag;
        logic [`DCACHE_DATA_W-1:0] rdata;
        logic [`DCACHE_DATA_W-1:0] wb_word;
    } way_result_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL,
        ST_RETRY
    } ctrl_state_t;

endpackage

//--- verilog/dcache_settings.svh
// Geometry of the 2-way write-back data cache.
// Include this header wherever address fields or array sizes are needed.
// The field widths below must agree with the set count and line length.

`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Word address and data widths
`define DCACHE_ADDR_W      19
`define DCACHE_DATA_W      16

// Set count and index width
`define DCACHE_SETS        16
`define DCACHE_INDEX_W     4

// Line length in words and word offset width
`define DCACHE_LINE_WORDS  8
`define DCACHE_OFFSET_W    3

// Remaining upper address bits form the tag
`define DCACHE_TAG_W       12

// The LRU scheme is a single bit per set, so this stays at 2
`define DCACHE_WAYS        2

`endif
